// ==== rtl/fp_pkg.sv ====
package fp_pkg;

  // Format encoding shared by every parameterized block
  typedef logic [1:0] fp_format_t;

  localparam fp_format_t FP32 = 2'd0;
  localparam fp_format_t FP16 = 2'd1;
  localparam fp_format_t BF16 = 2'd2;
  localparam fp_format_t FP8  = 2'd3;

  localparam int NUM_FORMATS = 4;

  // ------------------------------------------------------------------
  // Layout tables, indexed by the format code
  // ------------------------------------------------------------------
  // FP8 uses the E4M3 layout with IEEE special values
  localparam int EXP_TABLE [NUM_FORMATS] = '{8, 5, 8, 4};
  localparam int MAN_TABLE [NUM_FORMATS] = '{23, 10, 7, 3};

  function automatic int exp_bits(fp_format_t fmt);
    return EXP_TABLE[fmt];
  endfunction

  function automatic int man_bits(fp_format_t fmt);
    return MAN_TABLE[fmt];
  endfunction

  // Sign, exponent and mantissa
  function automatic int fp_width(fp_format_t fmt);
    return 1 + exp_bits(fmt) + man_bits(fmt);
  endfunction

  function automatic int bias(fp_format_t fmt);
    return (2 ** (exp_bits(fmt) - 1)) - 1;
  endfunction

  function automatic int maximum(int a, int b);
    return (a > b) ? a : b;
  endfunction

endpackage

// ==== rtl/fp_info_if.sv ====
`timescale 1ns/1ps

// Class flags of one operand
interface fp_info_if ();

  logic is_normal;
  logic is_subnormal;
  logic is_zero;
  logic is_inf;
  logic is_nan;
  logic is_signalling;

  // Classifier side drives the flags
  modport cls (
    output is_normal, is_subnormal, is_zero, is_inf, is_nan, is_signalling
  );

  // Adder side only reads them
  modport add (
    input is_normal, is_subnormal, is_zero, is_inf, is_nan, is_signalling
  );

endinterface

// ==== rtl/fp_classifier.sv ====
`timescale 1ns/1ps

module fp_classifier import fp_pkg::*; #(
  parameter fp_format_t FMT = FP32
) (
  input  logic [fp_width(FMT)-1:0] operand_i,
  fp_info_if.cls                   info
);

  localparam int WIDTH = fp_width(FMT);
  localparam int EXP_W = exp_bits(FMT);
  localparam int MAN_W = man_bits(FMT);

  logic [EXP_W-1:0] exp_field;
  logic [MAN_W-1:0] man_field;
  logic             exp_ones;
  logic             exp_zero;
  logic             man_zero;

  // Field split, sign bit sits above the exponent
  assign exp_field = operand_i[WIDTH-2 -: EXP_W];
  assign man_field = operand_i[MAN_W-1:0];

  assign exp_ones = &exp_field;
  assign exp_zero = ~|exp_field;
  assign man_zero = ~|man_field;

  assign info.is_normal    = !exp_ones && !exp_zero;
  assign info.is_subnormal = exp_zero && !man_zero;
  assign info.is_zero      = exp_zero && man_zero;
  assign info.is_inf       = exp_ones && man_zero;
  assign info.is_nan       = exp_ones && !man_zero;

  // Quiet bit is the top mantissa bit
  assign info.is_signalling = exp_ones && !man_zero && !man_field[MAN_W-1];

endmodule

// ==== rtl/lzc.sv ====
`timescale 1ns/1ps

module lzc import fp_pkg::*; #(
  parameter int WIDTH = 8
) (
  input  logic [WIDTH-1:0]         in_i,
  output logic [$clog2(WIDTH)-1:0] cnt_o,
  output logic                     empty_o
);

  localparam int CNT_W = $clog2(WIDTH);

  // Width check against the widest supported sum field
  localparam int MAX_WIDTH = 2 * maximum(man_bits(FP32) + 1, 8) + 2;

  initial begin
    if (WIDTH < 2 || WIDTH > 4 * MAX_WIDTH) begin
      $error("lzc: WIDTH out of range");
    end
  end

  assign empty_o = ~|in_i;

  // Priority search, the highest set bit is assigned last and wins
  always_comb begin
    cnt_o = CNT_W'(WIDTH - 1);
    for (int i = 0; i < WIDTH; i++) begin
      if (in_i[i]) begin
        cnt_o = CNT_W'(WIDTH - 1 - i);
      end
    end
  end

endmodule

// ==== rtl/fp_rounding.sv ====
`timescale 1ns/1ps

module fp_rounding import fp_pkg::*; #(
  parameter int ABS_WIDTH = exp_bits(FP32) + man_bits(FP32)
) (
  input  logic [ABS_WIDTH-1:0] abs_value_i,
  input  logic                 sign_i,
  input  logic [1:0]           round_sticky_i,
  output logic [ABS_WIDTH-1:0] abs_rounded_o,
  output logic                 sign_o,
  output logic                 exact_zero_o
);

  logic round_up;

  // Round to nearest, ties to even
  // round_sticky_i[1] is the round bit, [0] the sticky bit
  assign round_up = round_sticky_i[1] & (round_sticky_i[0] | abs_value_i[0]);

  // Mantissa carry ripples into the exponent field, which is intended
  assign abs_rounded_o = abs_value_i + ABS_WIDTH'(round_up);

  assign exact_zero_o = (abs_value_i == '0) && (round_sticky_i == 2'b00);

  // Exact zero from a cancellation is always positive under RNE
  assign sign_o = exact_zero_o ? 1'b0 : sign_i;

endmodule

// ==== rtl/fp_add.sv ====
`timescale 1ns/1ps

module fp_add import fp_pkg::*; #(
  parameter fp_format_t FMT_A   = FP32,
  parameter fp_format_t FMT_B   = FP32,
  parameter fp_format_t FMT_OUT = FP32
) (
  input  logic [fp_width(FMT_A)-1:0]   operand_a_i,
  input  logic [fp_width(FMT_B)-1:0]   operand_b_i,
  output logic [fp_width(FMT_OUT)-1:0] result_o
);

  // ------------------------------------------------------------------
  // Format constants
  // ------------------------------------------------------------------
  localparam int WA = fp_width(FMT_A);
  localparam int EA = exp_bits(FMT_A);
  localparam int MA = man_bits(FMT_A);
  localparam int BA = bias(FMT_A);
  localparam int WB = fp_width(FMT_B);
  localparam int EB = exp_bits(FMT_B);
  localparam int MB = man_bits(FMT_B);
  localparam int BB = bias(FMT_B);
  localparam int EC = exp_bits(FMT_OUT);
  localparam int MC = man_bits(FMT_OUT);
  localparam int BC = bias(FMT_OUT);

  localparam int PA = MA + 1;
  localparam int PB = MB + 1;
  localparam int PC = MC + 1;
  // Widest precision sets the alignment field
  localparam int PM    = maximum(PC, maximum(PA, PB));
  localparam int SUM_W = 2 * PM + 2;
  localparam int SH_W  = $clog2(SUM_W + 1);
  localparam int LZ_W  = $clog2(SUM_W);
  localparam int ESW   = maximum(EC, maximum(EA, EB)) + 3;

  localparam logic signed [ESW-1:0] SH_MAX_S  = ESW'(PC + 1);
  localparam logic signed [ESW-1:0] SUM_W_S   = ESW'(SUM_W);
  localparam logic signed [ESW-1:0] EXP_MAX_S = ESW'(2 ** EC - 1);

  // ------------------------------------------------------------------
  // Classification
  // ------------------------------------------------------------------
  fp_info_if info_a ();
  fp_info_if info_b ();

  fp_classifier #(.FMT(FMT_A)) u_class_a (.operand_i(operand_a_i), .info(info_a.cls));
  fp_classifier #(.FMT(FMT_B)) u_class_b (.operand_i(operand_b_i), .info(info_b.cls));

  logic          sign_a;
  logic          sign_b;
  logic [EA-1:0] exp_fa;
  logic [EB-1:0] exp_fb;
  logic [PA-1:0] man_a;
  logic [PB-1:0] man_b;
  logic          eff_sub;

  assign sign_a  = operand_a_i[WA-1];
  assign sign_b  = operand_b_i[WB-1];
  assign exp_fa  = operand_a_i[WA-2 -: EA];
  assign exp_fb  = operand_b_i[WB-2 -: EB];
  assign man_a   = {info_a.is_normal, operand_a_i[MA-1:0]};
  assign man_b   = {info_b.is_normal, operand_b_i[MB-1:0]};
  assign eff_sub = sign_a ^ sign_b;

  // ------------------------------------------------------------------
  // Special cases
  // ------------------------------------------------------------------
  logic                 is_special;
  logic [EC+MC:0]       special_result;

  always_comb begin
    is_special     = 1'b1;
    // Canonical quiet NaN
    special_result = {1'b0, {EC{1'b1}}, 1'b1, {(MC-1){1'b0}}};
    if (info_a.is_nan || info_b.is_nan) begin
      is_special = 1'b1;
    end else if (info_a.is_inf && info_b.is_inf && eff_sub) begin
      is_special = 1'b1;
    end else if (info_a.is_inf) begin
      special_result = {sign_a, {EC{1'b1}}, {MC{1'b0}}};
    end else if (info_b.is_inf) begin
      special_result = {sign_b, {EC{1'b1}}, {MC{1'b0}}};
    end else if (info_a.is_zero && info_b.is_zero) begin
      special_result = {sign_a & sign_b, {(EC+MC){1'b0}}};
    end else begin
      is_special = 1'b0;
    end
  end

  // ------------------------------------------------------------------
  // Exponents, re-biased into the output format
  // ------------------------------------------------------------------
  logic signed [ESW-1:0] exp_ra;
  logic signed [ESW-1:0] exp_rb;
  logic signed [ESW-1:0] exp_a;
  logic signed [ESW-1:0] exp_b;
  logic signed [ESW-1:0] exp_diff;
  logic signed [ESW-1:0] texp;
  logic [SH_W-1:0]       shamt_a;
  logic [SH_W-1:0]       shamt_b;

  // Subnormals count as exponent 1
  assign exp_ra = ESW'(exp_fa) + ESW'(info_a.is_subnormal) - ESW'(BA) + ESW'(BC);
  assign exp_rb = ESW'(exp_fb) + ESW'(info_b.is_subnormal) - ESW'(BB) + ESW'(BC);

  // A lone zero borrows the other exponent so it never wins alignment
  assign exp_a    = info_a.is_zero ? exp_rb : exp_ra;
  assign exp_b    = info_b.is_zero ? exp_ra : exp_rb;
  assign exp_diff = exp_a - exp_b;
  assign texp     = (exp_diff >= 0) ? exp_a : exp_b;

  always_comb begin
    shamt_a = '0;
    shamt_b = '0;
    if (exp_diff < 0) begin
      shamt_a = (-exp_diff > SH_MAX_S) ? SH_W'(PC + 1) : SH_W'(-exp_diff);
    end else begin
      shamt_b = (exp_diff > SH_MAX_S) ? SH_W'(PC + 1) : SH_W'(exp_diff);
    end
  end

  // ------------------------------------------------------------------
  // Alignment and add
  // ------------------------------------------------------------------
  logic [SUM_W-1:0] addend_a;
  logic [SUM_W-1:0] addend_b;
  logic [SUM_W-1:0] sum_raw;
  logic [SUM_W-1:0] sum;
  logic             sum_neg;
  logic             final_sign;

  // Hidden bits land on bit 2*PM, the top bit is the carry slot
  assign addend_a = (SUM_W'(man_a) << (2 * PM - PA + 1)) >> shamt_a;
  assign addend_b = (SUM_W'(man_b) << (2 * PM - PB + 1)) >> shamt_b;

  assign sum_raw = addend_a + (eff_sub ? ~addend_b : addend_b) + SUM_W'(eff_sub);
  assign sum_neg = eff_sub & sum_raw[SUM_W-1];
  assign sum     = sum_neg ? (~sum_raw + SUM_W'(1)) : sum_raw;

  // Negative difference means B was the larger magnitude
  assign final_sign = sum_neg ? sign_b : sign_a;

  // ------------------------------------------------------------------
  // Normalization
  // ------------------------------------------------------------------
  logic [LZ_W-1:0]       lz_cnt;
  logic                  sum_zero;
  logic signed [ESW-1:0] lz_s;
  logic signed [ESW-1:0] norm_exp;
  logic signed [ESW-1:0] neg_texp;
  logic signed [ESW-1:0] final_exp;
  logic [2*SUM_W-1:0]    ext;
  logic [2*SUM_W-1:0]    shifted;

  lzc #(.WIDTH(SUM_W)) u_lzc (.in_i(sum), .cnt_o(lz_cnt), .empty_o(sum_zero));

  assign lz_s     = ESW'(lz_cnt);
  assign norm_exp = texp - lz_s + 1;
  assign neg_texp = -texp;
  assign ext      = {sum, {SUM_W{1'b0}}};

  always_comb begin
    final_exp = '0;
    if (!sum_zero && norm_exp > 0) begin
      shifted   = ext << lz_cnt;
      final_exp = norm_exp;
    end else if (texp >= 0) begin
      // Subnormal result, top bit then carries the weight of exponent 1
      shifted = ext << texp[SH_W-1:0];
    end else if (neg_texp >= SUM_W_S) begin
      shifted = ext >> SUM_W;
    end else begin
      shifted = ext >> neg_texp[SH_W-1:0];
    end
  end

  // ------------------------------------------------------------------
  // Saturation and rounding
  // ------------------------------------------------------------------
  logic                overflow;
  logic [EC-1:0]       pre_exp;
  logic [MC-1:0]       pre_man;
  logic [1:0]          round_sticky;
  logic [EC+MC-1:0]    rounded_abs;
  logic                rounded_sign;
  logic                exact_zero;
  logic [EC+MC:0]      regular_result;

  assign overflow = final_exp >= EXP_MAX_S;
  assign pre_exp  = overflow ? EC'(2 ** EC - 2) : final_exp[EC-1:0];
  assign pre_man  = overflow ? {MC{1'b1}} : shifted[2*SUM_W-2 -: MC];

  // Largest finite plus a forced round up gives infinity
  assign round_sticky = overflow ? 2'b11 :
                        {shifted[2*SUM_W-1-PC], |shifted[2*SUM_W-2-PC:0]};

  fp_rounding #(.ABS_WIDTH(EC + MC)) u_round (
    .abs_value_i   ({pre_exp, pre_man}),
    .sign_i        (final_sign),
    .round_sticky_i(round_sticky),
    .abs_rounded_o (rounded_abs),
    .sign_o        (rounded_sign),
    .exact_zero_o  (exact_zero)
  );

  // Exact zero only ever carries a positive sign out of the rounder
  assign regular_result = {rounded_sign & !exact_zero, rounded_abs};
  assign result_o       = is_special ? special_result : regular_result;

endmodule

// ==== rtl/fp_add_unit.sv ====
`timescale 1ns/1ps

module fp_add_unit import fp_pkg::*; #(
  parameter fp_format_t FMT_A   = FP16,
  parameter fp_format_t FMT_B   = BF16,
  parameter fp_format_t FMT_OUT = FP32
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         valid_i,
  input  logic [fp_width(FMT_A)-1:0]   operand_a_i,
  input  logic [fp_width(FMT_B)-1:0]   operand_b_i,
  output logic                         valid_o,
  output logic [fp_width(FMT_OUT)-1:0] result_o
);

  localparam int WA   = fp_width(FMT_A);
  localparam int WB   = fp_width(FMT_B);
  localparam int WOUT = fp_width(FMT_OUT);

  // ------------------------------------------------------------------
  // Stage 1, operand capture
  // ------------------------------------------------------------------
  logic [WA-1:0]   operand_a_q;
  logic [WB-1:0]   operand_b_q;
  logic            valid_q;
  logic [WOUT-1:0] sum_d;

  // Operands load only on a strobe
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      operand_a_q <= operand_a_i;
      operand_b_q <= operand_b_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  fp_add #(
    .FMT_A  (FMT_A),
    .FMT_B  (FMT_B),
    .FMT_OUT(FMT_OUT)
  ) u_fp_add (
    .operand_a_i(operand_a_q),
    .operand_b_i(operand_b_q),
    .result_o   (sum_d)
  );

  // ------------------------------------------------------------------
  // Stage 2, result capture
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
    end else begin
      valid_o <= valid_q;
      // Result holds between strobes
      if (valid_q) begin
        result_o <= sum_d;
      end
    end
  end

endmodule

// ==== sim/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset releases on a falling edge, away from the sampling edge
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

// ==== sim/fp_add_unit_chk.sv ====
`timescale 1ns/1ps

module fp_add_unit_chk (
  input logic clk_i,
  input logic rst_i,
  input logic valid_in_i,
  input logic valid_out_i
);

  // A reset cycle leaves the output strobe low on the next edge
  assert property (@(posedge clk_i) rst_i |=> !valid_out_i)
    else $error("valid_o high after a reset cycle");

  // Fixed two-stage latency, one output pulse per input strobe
  assert property (@(posedge clk_i) disable iff (rst_i)
                   valid_out_i == $past(valid_in_i, 2))
    else $error("valid_o does not follow valid_i by two cycles");

  assert property (@(posedge clk_i) disable iff (rst_i) !$isunknown(valid_out_i))
    else $error("valid_o is unknown after reset");

endmodule

bind fp_add_unit fp_add_unit_chk chk0 (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .valid_in_i (valid_i),
  .valid_out_i(valid_o)
);

// ==== sim/tb_fp_add_unit.sv ====
`timescale 1ns/1ps

module tb_fp_add_unit import fp_pkg::*; ();

  localparam int NUM_VECTORS = 22;
  localparam int WAIT_LIMIT  = 32;

  typedef struct packed {
    logic [15:0] op_a;
    logic [15:0] op_b;
    logic [31:0] expected;
    logic        back_to_back;
  } vector_t;

  // FP16 operand, BF16 operand, FP32 sum, strobe right after the previous one
  localparam vector_t VECTORS [NUM_VECTORS] = '{
    '{16'h3E00, 16'h4010, 32'h40700000, 1'b0},  // 1.5 + 2.25
    '{16'h4200, 16'h3F80, 32'h40800000, 1'b1},  // 3.0 + 1.0
    '{16'h0000, 16'h4049, 32'h40490000, 1'b1},  // +0 + 3.140625
    '{16'hC500, 16'h0000, 32'hC0A00000, 1'b0},  // -5.0 + +0
    '{16'h3C00, 16'hBFC0, 32'hBF000000, 1'b0},  // 1.0 - 1.5
    '{16'h4000, 16'hC000, 32'h00000000, 1'b1},  // 2.0 - 2.0
    '{16'hBC00, 16'h3F80, 32'h00000000, 1'b0},  // -1.0 + 1.0
    '{16'h3C01, 16'h3F80, 32'h40001000, 1'b1},  // Carry into a new exponent
    '{16'h7800, 16'h3880, 32'h47000000, 1'b0},  // 32768 + 2^-14
    '{16'h7BFF, 16'h7F7F, 32'h7F7F0000, 1'b0},  // FP16 max + BF16 max
    '{16'h0001, 16'h3F80, 32'h3F800000, 1'b1},  // Tie, stays even
    '{16'h0003, 16'h3F80, 32'h3F800002, 1'b1},  // Tie, rounds up to even
    '{16'h0200, 16'h3F80, 32'h3F800100, 1'b0},  // 2^-15 subnormal + 1.0
    '{16'h7E00, 16'h3F80, 32'h7FC00000, 1'b0},  // Quiet NaN in A
    '{16'h3C00, 16'h7FC1, 32'h7FC00000, 1'b1},  // NaN in B
    '{16'h7C01, 16'h0000, 32'h7FC00000, 1'b0},  // Signalling NaN in A
    '{16'h7C00, 16'hFF80, 32'h7FC00000, 1'b0},  // +inf - inf
    '{16'h7C00, 16'h4000, 32'h7F800000, 1'b1},  // +inf + 2.0
    '{16'h3C00, 16'hFF80, 32'hFF800000, 1'b0},  // 1.0 + -inf
    '{16'h0000, 16'h0000, 32'h00000000, 1'b0},  // +0 + +0
    '{16'h8000, 16'h8000, 32'h80000000, 1'b1},  // -0 + -0
    '{16'h0000, 16'h8000, 32'h00000000, 1'b0}   // +0 + -0
  };

  logic        clk_i;
  logic        rst_i;
  logic        valid_i;
  logic [15:0] operand_a_i;
  logic [15:0] operand_b_i;
  logic        valid_o;
  logic [31:0] result_o;

  logic [31:0] expected_q [$];
  int          strobe_q [$];
  logic [31:0] expected;
  logic [31:0] last_result;
  int          strobe_cycle;
  int          cycle_cnt;
  int          error_count;
  int          check_count;
  int          seed;
  int          gap;
  int          wait_cycles;
  bit          timed_out;

  clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(8)) clk_gen0 (.clk_o(clk_i), .rst_o(rst_i));

  fp_add_unit #(.FMT_A(FP16), .FMT_B(BF16), .FMT_OUT(FP32)) dut0 (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .valid_i    (valid_i),
    .operand_a_i(operand_a_i),
    .operand_b_i(operand_b_i),
    .valid_o    (valid_o),
    .result_o   (result_o)
  );

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ------------------------------------------------------------------
  // Scoreboard, each valid_o pulse retires the oldest strobe
  // ------------------------------------------------------------------
  always @(negedge clk_i) begin
    if (!rst_i && valid_o) begin
      if (expected_q.size() == 0) begin
        $display("valid_o went high with no operation pending");
        error_count++;
      end else begin
        expected     = expected_q.pop_front();
        strobe_cycle = strobe_q.pop_front();
        check_count++;
        if (result_o !== expected) begin
          $display("Fail result_o expected %h actual %h", expected, result_o);
          error_count++;
        end
        if (cycle_cnt - strobe_cycle != 2) begin
          $display("Fail valid_o latency expected %h actual %h", 2, cycle_cnt - strobe_cycle);
          error_count++;
        end
      end
      last_result = result_o;
    end else if (!rst_i && result_o !== last_result) begin
      // Between pulses result_o keeps the last value
      $display("Fail result_o hold expected %h actual %h", last_result, result_o);
      error_count++;
    end
  end

  initial begin
    seed        = 71;
    error_count = 0;
    check_count = 0;
    last_result = '0;
    timed_out   = 1'b0;
    valid_i     = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;

    @(negedge clk_i);
    wait_cycles = 0;
    while (rst_i && wait_cycles < WAIT_LIMIT) begin
      if (valid_o !== 1'b0) begin
        $display("Fail valid_o in reset expected %h actual %h", 1'b0, valid_o);
        error_count++;
      end
      @(negedge clk_i);
      wait_cycles++;
    end
    timed_out = rst_i;

    if (timed_out) begin
      $display("Reset did not release within the wait limit");
    end else begin
      if (result_o !== 32'h0) begin
        $display("Fail result_o after reset expected %h actual %h", 32'h0, result_o);
        error_count++;
      end
      // Idle before the first strobe
      repeat (3) begin
        @(negedge clk_i);
        if (valid_o !== 1'b0) begin
          $display("Fail valid_o before first strobe expected %h actual %h", 1'b0, valid_o);
          error_count++;
        end
      end

      for (int idx = 0; idx < NUM_VECTORS; idx++) begin
        if (!VECTORS[idx].back_to_back) begin
          gap = $unsigned($random(seed)) % 3 + 1;
          // Operands wander while idle and must not reach the result
          repeat (gap) begin
            operand_a_i = 16'($random(seed));
            operand_b_i = 16'($random(seed));
            @(negedge clk_i);
          end
        end
        valid_i     = 1'b1;
        operand_a_i = VECTORS[idx].op_a;
        operand_b_i = VECTORS[idx].op_b;
        expected_q.push_back(VECTORS[idx].expected);
        strobe_q.push_back(cycle_cnt);
        @(negedge clk_i);
        valid_i = 1'b0;
      end

      wait_cycles = 0;
      while (expected_q.size() != 0 && wait_cycles < WAIT_LIMIT) begin
        @(negedge clk_i);
        wait_cycles++;
      end
      timed_out = (expected_q.size() != 0);
      if (timed_out) begin
        $display("Timed out waiting for valid_o, %0d results missing", expected_q.size());
      end
    end

    $display("Checks %0d, errors %0d", check_count, error_count);
    if (timed_out || error_count != 0) begin
      $display("Errors found");
    end else begin
      $display("No errors");
    end
    $finish;
  end

endmodule

// ==== all.f ====
rtl/fp_pkg.sv
rtl/fp_info_if.sv
rtl/fp_classifier.sv
rtl/lzc.sv
rtl/fp_rounding.sv
rtl/fp_add.sv
rtl/fp_add_unit.sv
sim/clk_gen.sv
sim/fp_add_unit_chk.sv
sim/tb_fp_add_unit.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_fp_add_unit -f all.f > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/Vtb_fp_add_unit > sim.log 2>&1
grep -qx "No errors" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
